// File: ext_mem.f
+incdir+verilog
verilog/mem_bus_pkg.sv
verilog/cache_pkg.sv
verilog/wt_cache.sv
verilog/bus_merge.sv
verilog/main_ram.sv
verilog/ext_mem.sv
tests/ext_mem_props.sv
tests/ext_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; passes only if the testbench prints its pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ext_mem.f --top-module ext_mem_tb -o ext_mem_sim \
   && ./obj_dir/ext_mem_sim | tee /dev/stderr | grep -qx "TEST OK" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// File: tests/ext_mem_tb.sv
`default_nettype none

`include "ext_mem_settings.svh"

module ext_mem_tb
   import mem_bus_pkg::*;
();

   localparam int AW          = `EXT_MEM_ADDR_W;
   localparam int DW          = `EXT_MEM_DATA_W;
   localparam int ACK_TIMEOUT = 64;

   logic      clk_i;
   logic      rst_i;
   mem_req_t  i_req;
   dreq_t     d_req;
   mem_resp_t i_resp;
   mem_resp_t d_resp;

   logic [DW-1:0] ref_mem [1 << AW];   // Expected contents of the whole hierarchy
   bit            known   [1 << AW];
   logic [31:0]   lcg_state;
   int            checks;
   int            mismatches;
   int            failures;

   ext_mem dut0 (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .i_req_i  (i_req),
      .i_resp_o (i_resp),
      .d_req_i  (d_req),
      .d_resp_o (d_resp)
   );

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [DW-1:0] merge_bytes(logic [DW-1:0] old, logic [DW-1:0] wdata,
                                                 logic [3:0] wstrb);
      logic [DW-1:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (wstrb[b])
            res[8*b +: 8] = wdata[8*b +: 8];
      end
      return res;
   endfunction

   task automatic check_word(input string name, input logic [AW-1:0] addr,
                             input logic [DW-1:0] got, input logic [DW-1:0] exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s at address %h: got %h, expected %h", name, addr, got, exp);
      end
   endtask

   // One data bus transfer, request held until the ack
   task automatic data_access(input logic ctrl, input logic [AW-1:0] addr,
                              input logic [DW-1:0] wdata, input logic [3:0] wstrb,
                              output logic [DW-1:0] rdata, output bit ok);
      int waited;
      ok     = 1'b0;
      waited = 0;
      @(posedge clk_i);
      d_req.ctrl      <= ctrl;
      d_req.bus.req   <= 1'b1;
      d_req.bus.addr  <= addr;
      d_req.bus.wdata <= wdata;
      d_req.bus.wstrb <= wstrb;
      while (!ok && waited < ACK_TIMEOUT) begin
         @(negedge clk_i);   // Sample mid-cycle
         if (d_resp.ack) begin
            ok    = 1'b1;
            rdata = d_resp.rdata;
         end
         waited++;
      end
      @(posedge clk_i);
      d_req.bus.req <= 1'b0;
      if (!ok) begin
         failures++;
         $display("Data request to address %h got no ack within %0d cycles", addr, ACK_TIMEOUT);
      end
   endtask

   task automatic fetch_check(input logic [AW-1:0] addr);
      int  waited;
      bit  ok;
      ok     = 1'b0;
      waited = 0;
      @(posedge clk_i);
      i_req.req   <= 1'b1;
      i_req.addr  <= addr;
      i_req.wdata <= '0;
      i_req.wstrb <= 4'h0;
      while (!ok && waited < ACK_TIMEOUT) begin
         @(negedge clk_i);
         if (i_resp.ack) begin
            ok = 1'b1;
            check_word("i_resp_o.rdata", addr, i_resp.rdata, ref_mem[addr]);
         end
         waited++;
      end
      @(posedge clk_i);
      i_req.req <= 1'b0;
      if (!ok) begin
         failures++;
         $display("Fetch from address %h got no ack within %0d cycles", addr, ACK_TIMEOUT);
      end
   endtask

   task automatic write_data(input logic [AW-1:0] addr, input logic [DW-1:0] wdata,
                             input logic [3:0] wstrb);
      logic [DW-1:0] unused_rdata;
      bit            ok;
      data_access(1'b0, addr, wdata, wstrb, unused_rdata, ok);
      ref_mem[addr] = merge_bytes(ref_mem[addr], wdata, wstrb);
      known[addr]   = 1'b1;
   endtask

   task automatic read_data(input logic [AW-1:0] addr);
      logic [DW-1:0] rdata;
      bit            ok;
      data_access(1'b0, addr, '0, 4'h0, rdata, ok);
      if (ok)
         check_word("d_resp_o.rdata", addr, rdata, ref_mem[addr]);
   endtask

   task automatic test_write_read();
      write_data(12'h005, 32'ha5a5_0f0f, 4'hf);
      read_data(12'h005);
      write_data(12'h005, 32'h1122_3344, 4'b0101);   // Write hit, two bytes
      read_data(12'h005);
      write_data(12'h045, 32'hdead_beef, 4'hf);      // Same index, other tag
      read_data(12'h045);
      read_data(12'h005);
      write_data(12'h045, 32'h5566_7788, 4'b1010);
      read_data(12'h045);
   endtask

   task automatic test_fetch_after_write();
      write_data(12'h123, 32'h0bad_f00d, 4'hf);
      write_data(12'h133, 32'hcafe_0123, 4'hf);
      fetch_check(12'h123);
      fetch_check(12'h133);   // Evicts the line above in the I-cache
      fetch_check(12'h123);
   endtask

   task automatic test_random();
      logic [31:0]   r;
      logic [AW-1:0] addr;
      logic [3:0]    strb;
      for (int n = 0; n < 64; n++) begin
         r    = next_rand();
         addr = 12'h400 | (r[27:16] & 12'h307);   // 32 addresses, many share an index
         if (known[addr] && r[31]) begin
            read_data(addr);
         end else begin
            strb = (known[addr] && r[7:4] != 4'h0) ? r[7:4] : 4'hf;
            write_data(addr, next_rand(), strb);
         end
      end
   endtask

   // I-side and D-side requests raised on the same edge
   task automatic test_parallel();
      logic [DW-1:0] wdata;
      for (int k = 0; k < 4; k++) begin
         write_data(AW'(12'h200 + k), next_rand(), 4'hf);
         write_data(AW'(12'h280 + k), next_rand(), 4'hf);
      end
      for (int k = 0; k < 4; k++) begin
         wdata = next_rand();
         fork
            fetch_check(AW'(12'h200 + k));
            begin
               if (k % 2 == 0)
                  write_data(AW'(12'h280 + k), wdata, 4'hf);
               else
                  read_data(AW'(12'h280 + k));
            end
         join
      end
      for (int k = 0; k < 4; k++)
         read_data(AW'(12'h280 + k));
   endtask

   task automatic test_control();
      logic [DW-1:0] rdata;
      bit            ok;
      bit            idle_seen;
      idle_seen = 1'b0;
      data_access(1'b1, '0, 32'h1, 4'hf, rdata, ok);   // Flush D-cache and L2
      read_data(12'h005);
      read_data(12'h045);
      read_data(12'h133);
      for (int a = 12'h400; a < 12'h408; a++) begin
         if (known[a])
            read_data(AW'(a));
      end
      for (int t = 0; t < 16 && !idle_seen; t++) begin
         data_access(1'b1, '0, '0, 4'h0, rdata, ok);
         if (ok && rdata[0])
            idle_seen = 1'b1;
      end
      checks++;
      if (!idle_seen) begin
         failures++;
         $display("Control read never reported the L2 as idle");
      end
   endtask

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   initial begin
      rst_i      = 1'b1;
      i_req      = '0;
      d_req      = '0;
      lcg_state  = 32'h3e1a6db5;
      checks     = 0;
      mismatches = 0;
      failures   = 0;
      repeat (10) @(posedge clk_i);
      rst_i <= 1'b0;
      test_write_read();
      test_fetch_after_write();
      test_random();
      test_parallel();
      test_control();
      $display("Checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/ext_mem_props.sv
`default_nettype none

module ext_mem_props
   import mem_bus_pkg::*;
(
   input wire            clk_i,
   input wire            rst_i,
   input wire mem_resp_t i_resp_i,
   input wire mem_resp_t d_resp_i,
   input wire mem_req_t  m0_req_i,    // I-cache back-end request
   input wire mem_req_t  m1_req_i,    // D-cache back-end request
   input wire mem_resp_t m0_resp_i,   // Merger ack toward the I-cache
   input wire mem_resp_t m1_resp_i,   // Merger ack toward the D-cache
   input wire mem_resp_t l2_resp_i,
   input wire            l2_idle_i,
   input wire            l2_inv_i
);

   i_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
      i_resp_i.ack |=> !i_resp_i.ack) else $error("I-cache ack longer than one cycle");

   d_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
      d_resp_i.ack |=> !d_resp_i.ack) else $error("D-cache ack longer than one cycle");

   l2_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
      l2_resp_i.ack |=> !l2_resp_i.ack) else $error("L2 ack longer than one cycle");

   // One grant at a time, and only to a waiting master
   m0_ack_owner: assert property (@(posedge clk_i) disable iff (rst_i)
      m0_resp_i.ack |-> m0_req_i.req && !m1_resp_i.ack)
      else $error("Merger ack to the I-cache without its grant");

   m1_ack_owner: assert property (@(posedge clk_i) disable iff (rst_i)
      m1_resp_i.ack |-> m1_req_i.req)
      else $error("Merger ack to the D-cache without a pending request");

   l2_inv_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
      l2_inv_i |-> l2_idle_i) else $error("L2 invalidate during an L2 access");

endmodule

bind ext_mem ext_mem_props props0 (
   .clk_i     (clk_i),
   .rst_i     (rst_i),
   .i_resp_i  (i_resp_o),
   .d_resp_i  (d_resp_o),
   .m0_req_i  (icache_be_req),
   .m1_req_i  (dcache_be_req),
   .m0_resp_i (icache_be_resp),
   .m1_resp_i (dcache_be_resp),
   .l2_resp_i (l2_resp),
   .l2_idle_i (l2_idle),
   .l2_inv_i  (l2_invalidate)
);

`default_nettype wire

// File: verilog/ext_mem.sv
`default_nettype none

`include "ext_mem_settings.svh"

module ext_mem
   import mem_bus_pkg::*;
(
   input  wire       clk_i,
   input  wire       rst_i,
   input  wire       mem_req_t i_req_i,
   output mem_resp_t i_resp_o,
   input  wire       dreq_t d_req_i,
   output mem_resp_t d_resp_o
);

   mem_req_t  icache_be_req;
   mem_resp_t icache_be_resp;
   mem_req_t  dcache_be_req;
   mem_resp_t dcache_be_resp;
   mem_req_t  l2_req;
   mem_resp_t l2_resp;
   mem_req_t  ram_req;
   mem_resp_t ram_resp;

   logic d_invalidate;     // Pulse from a D-cache control write
   logic l2_idle;
   logic inv_guard_q;
   logic l2_invalidate;

   // Pending L2 flush waits for a gap in L2 traffic
   assign l2_invalidate = inv_guard_q && !l2_req.req;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i)
         inv_guard_q <= 1'b0;
      else if (d_invalidate)
         inv_guard_q <= 1'b1;
      else if (!l2_req.req)
         inv_guard_q <= 1'b0;
   end

   wt_cache #(.IDX_W(`EXT_MEM_L1_IDX_W), .USE_CTRL(1'b0)) icache (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .fe_req_i     (i_req_i),
      .fe_ctrl_i    (1'b0),
      .fe_resp_o    (i_resp_o),
      .be_req_o     (icache_be_req),
      .be_resp_i    (icache_be_resp),
      .invalidate_i (1'b0),
      .invalidate_o (),
      .be_idle_i    (1'b1),
      .idle_o       ()
   );

   wt_cache #(.IDX_W(`EXT_MEM_L1_IDX_W), .USE_CTRL(1'b1)) dcache (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .fe_req_i     (d_req_i.bus),
      .fe_ctrl_i    (d_req_i.ctrl),
      .fe_resp_o    (d_resp_o),
      .be_req_o     (dcache_be_req),
      .be_resp_i    (dcache_be_resp),
      .invalidate_i (1'b0),
      .invalidate_o (d_invalidate),
      .be_idle_i    (l2_idle),   // Reported by control reads
      .idle_o       ()
   );

   // D-cache is master 1 and takes priority
   bus_merge merge0 (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .m_req_i  ({dcache_be_req, icache_be_req}),
      .m_resp_o ({dcache_be_resp, icache_be_resp}),
      .s_req_o  (l2_req),
      .s_resp_i (l2_resp)
   );

   wt_cache #(.IDX_W(`EXT_MEM_L2_IDX_W), .USE_CTRL(1'b0)) l2cache (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .fe_req_i     (l2_req),
      .fe_ctrl_i    (1'b0),
      .fe_resp_o    (l2_resp),
      .be_req_o     (ram_req),
      .be_resp_i    (ram_resp),
      .invalidate_i (l2_invalidate),
      .invalidate_o (),
      .be_idle_i    (1'b1),
      .idle_o       (l2_idle)
   );

   main_ram ram0 (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .req_i  (ram_req),
      .resp_o (ram_resp)
   );

endmodule

`default_nettype wire

// File: verilog/main_ram.sv
`default_nettype none

`include "ext_mem_settings.svh"

module main_ram
   import mem_bus_pkg::*;
(
   input  wire       clk_i,
   input  wire       rst_i,
   input  wire       mem_req_t req_i,
   output mem_resp_t resp_o
);

   localparam int DEPTH = 1 << `EXT_MEM_ADDR_W;
   localparam int CNT_W = $clog2(`EXT_MEM_RAM_LAT + 1);

   logic [`EXT_MEM_DATA_W-1:0] mem_q [DEPTH];
   logic [`EXT_MEM_DATA_W-1:0] rdata_q;
   logic [CNT_W-1:0]           cnt_q;
   logic [CNT_W-1:0]           elapsed;
   logic                       busy_q;
   logic                       ack_q;
   logic                       fire;

   assign elapsed = busy_q ? cnt_q : '0;   // Edges seen so far
   assign fire    = req_i.req && !ack_q && (elapsed == CNT_W'(`EXT_MEM_RAM_LAT - 1));

   assign resp_o.rdata = rdata_q;
   assign resp_o.ack   = ack_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
         ack_q  <= 1'b0;
      end else begin
         ack_q <= fire;
         if (fire) begin
            busy_q <= 1'b0;
         end else if (req_i.req && !ack_q) begin
            busy_q <= 1'b1;
            cnt_q  <= elapsed + 1'b1;
         end
      end
   end

   // Access happens on the last delay edge
   always_ff @(posedge clk_i) begin
      if (fire) begin
         rdata_q <= mem_q[req_i.addr];
         for (int b = 0; b < 4; b++) begin
            if (req_i.wstrb[b])
               mem_q[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/bus_merge.sv
`default_nettype none

module bus_merge
   import mem_bus_pkg::*;
(
   input  wire             clk_i,
   input  wire             rst_i,
   input  wire             mem_req_t [1:0] m_req_i,
   output mem_resp_t [1:0] m_resp_o,
   output mem_req_t        s_req_o,
   input  wire             mem_resp_t s_resp_i
);

   logic busy_q;
   logic sel_q;
   logic sel;

   // Master 1 wins when free, grant frozen while busy
   assign sel = busy_q ? sel_q : m_req_i[1].req;

   assign s_req_o = m_req_i[sel];

   always_comb begin
      for (int m = 0; m < 2; m++) begin
         m_resp_o[m].rdata = s_resp_i.rdata;
         m_resp_o[m].ack   = s_resp_i.ack && (sel == m[0]);
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy_q <= 1'b0;
         sel_q  <= 1'b0;
      end else if (busy_q) begin
         if (s_resp_i.ack)
            busy_q <= 1'b0; // Released on the slave ack
      end else if (s_req_o.req) begin
         busy_q <= 1'b1;
         sel_q  <= sel;
      end
   end

endmodule

`default_nettype wire

// File: verilog/wt_cache.sv
`default_nettype none

`include "ext_mem_settings.svh"

module wt_cache
   import mem_bus_pkg::*;
   import cache_pkg::*;
#(
   parameter int IDX_W    = `EXT_MEM_L1_IDX_W,
   parameter bit USE_CTRL = 1'b0
) (
   input  wire       clk_i,
   input  wire       rst_i,
   input  wire       mem_req_t fe_req_i,
   input  wire       fe_ctrl_i,
   output mem_resp_t fe_resp_o,
   output mem_req_t  be_req_o,
   input  wire       mem_resp_t be_resp_i,
   input  wire       invalidate_i,
   output logic      invalidate_o,
   input  wire       be_idle_i,
   output logic      idle_o
);

   localparam int NLINES = 1 << IDX_W;

   typedef enum logic [1:0] {
      S_IDLE,
      S_LOOKUP,
      S_BE_WAIT,
      S_RESP
   } state_t;

   state_t                     state_q;
   mem_req_t                   req_q;
   logic                       ctrl_q;
   logic [`EXT_MEM_DATA_W-1:0] rdata_q;
   line_t                      lines_q [NLINES];

   cache_addr_u                addr_u;
   logic [IDX_W-1:0]           idx;
   tag_t                       tag;
   line_t                      line;
   logic                       is_wr;
   logic                       ctrl_sel;
   logic                       hit;
   logic                       quick_ack;
   logic [`EXT_MEM_DATA_W-1:0] quick_rdata;
   logic [`EXT_MEM_DATA_W-1:0] merged;

   assign addr_u.word = req_q.addr;
   assign idx         = addr_u.f.idx[IDX_W-1:0];
   assign tag         = tag_t'(addr_u.word >> IDX_W); // Upper bits above the index
   assign line        = lines_q[idx];

   assign is_wr    = |req_q.wstrb;
   assign ctrl_sel = USE_CTRL && ctrl_q;
   assign hit      = line.valid && (line.tag == tag);

   // Hits and control accesses answer straight from lookup
   assign quick_ack   = (state_q == S_LOOKUP) && (ctrl_sel || (!is_wr && hit));
   assign quick_rdata = ctrl_sel ? {{(`EXT_MEM_DATA_W-1){1'b0}}, be_idle_i} : line.data;

   assign fe_resp_o.ack   = quick_ack || (state_q == S_RESP);
   assign fe_resp_o.rdata = (state_q == S_LOOKUP) ? quick_rdata : rdata_q;

   assign invalidate_o = (state_q == S_LOOKUP) && ctrl_sel && is_wr;
   assign idle_o       = (state_q == S_IDLE);

   always_comb begin
      be_req_o     = req_q;
      be_req_o.req = (state_q == S_BE_WAIT);
   end

   // Write data merged into the cached word
   always_comb begin
      merged = line.data;
      for (int b = 0; b < 4; b++) begin
         if (req_q.wstrb[b])
            merged[8*b +: 8] = req_q.wdata[8*b +: 8];
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= S_IDLE;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (fe_req_i.req)
                  state_q <= S_LOOKUP;
            end
            S_LOOKUP:  state_q <= quick_ack ? S_IDLE : S_BE_WAIT;
            S_BE_WAIT: begin
               if (be_resp_i.ack)
                  state_q <= S_RESP;
            end
            default:   state_q <= S_IDLE; // Ack cycle done
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == S_IDLE) begin
         req_q  <= fe_req_i;
         ctrl_q <= fe_ctrl_i;
      end
      if (state_q == S_BE_WAIT && be_resp_i.ack)
         rdata_q <= be_resp_i.rdata;
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         for (int i = 0; i < NLINES; i++)
            lines_q[i].valid <= 1'b0;
      end else begin
         if (state_q == S_LOOKUP && is_wr && hit && !ctrl_sel)
            lines_q[idx].data <= merged; // Write hit, no allocate on miss
         if (state_q == S_BE_WAIT && be_resp_i.ack && !is_wr)
            lines_q[idx] <= '{valid: 1'b1, tag: tag, data: be_resp_i.rdata};
         // Flush wins over a fill in the same cycle
         if (invalidate_i || invalidate_o) begin
            for (int i = 0; i < NLINES; i++)
               lines_q[i].valid <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/cache_pkg.sv
`default_nettype none

`include "ext_mem_settings.svh"

package cache_pkg;

   // Widest tag, needed by the L1 caches; the L2 uses its low part
   typedef logic [`EXT_MEM_ADDR_W-`EXT_MEM_L1_IDX_W-1:0] tag_t;

   typedef struct packed {
      logic [`EXT_MEM_ADDR_W-`EXT_MEM_L2_IDX_W-1:0] tag;
      logic [`EXT_MEM_L2_IDX_W-1:0]                 idx;
   } addr_fields_t;

   // Same address word, flat or split
   // L1 caches take only the low bits of idx
   typedef union packed {
      logic [`EXT_MEM_ADDR_W-1:0] word;
      addr_fields_t               f;
   } cache_addr_u;

   typedef struct packed {
      logic                       valid;
      tag_t                       tag;
      logic [`EXT_MEM_DATA_W-1:0] data;
   } line_t;

endpackage

`default_nettype wire

// File: verilog/mem_bus_pkg.sv
`default_nettype none

`include "ext_mem_settings.svh"

package mem_bus_pkg;

   // Native bus request, fields held steady until ack
   typedef struct packed {
      logic                       req;   // Level, high while pending
      logic [`EXT_MEM_ADDR_W-1:0] addr;  // Word address
      logic [`EXT_MEM_DATA_W-1:0] wdata;
      logic [3:0]                 wstrb; // All zero for a read
   } mem_req_t;

   typedef struct packed {
      logic [`EXT_MEM_DATA_W-1:0] rdata;
      logic                       ack;   // One-cycle pulse
   } mem_resp_t;

   // Data bus adds the control space select
   typedef struct packed {
      logic     ctrl;
      mem_req_t bus;
   } dreq_t;

endpackage

`default_nettype wire

// File: verilog/ext_mem_settings.svh
`ifndef EXT_MEM_SETTINGS_SVH
`define EXT_MEM_SETTINGS_SVH

// Word address width, shared by every level of the hierarchy
`define EXT_MEM_ADDR_W 12

`define EXT_MEM_DATA_W 32

// Index widths, one word per line
`define EXT_MEM_L1_IDX_W 4
`define EXT_MEM_L2_IDX_W 6

// Main memory response delay in cycles
`define EXT_MEM_RAM_LAT 2

`endif
